//--- dv/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
	input  logic restart,  // start another reset sequence
	output logic clk,
	output logic reset
);

	logic       clk_r = 1'b0;
	logic [1:0] rst_left = 2'd3;  // reset cycles still to go

	assign clk = clk_r;
	assign reset = (rst_left != 2'd0);

	always #20 clk_r = ~clk_r;  // 40 ns period

	always @(posedge clk_r) begin
		if (restart)
			rst_left <= 2'd3;
		else if (rst_left != 2'd0)
			rst_left <= rst_left - 2'd1;
	end

endmodule

//--- dv/tb_mem.sv
`timescale 1ns/100ps

module tb_mem (
	input  logic        clk,
	input  logic        reset,
	input  logic        load,          // copy image into memory
	input  logic [31:0] image [1024],
	input  logic        wb_cyc,
	input  logic        wb_stb,
	input  logic        wb_we,
	input  logic [31:0] wb_adr,
	input  logic [31:0] wb_dat_w,
	output logic [31:0] wb_dat_r,
	output logic        wb_ack,
	output logic        wr_seen,       // one cycle per completed write
	output logic [31:0] wr_addr,
	output logic [31:0] wr_data
);

	logic [31:0] mem [1024];
	logic [31:0] dat_q = '0;
	logic        ack_q = 1'b0;
	logic        busy = 1'b0;
	logic [1:0]  wait_left = 2'd0;  // extra ack delay
	integer      seed = 72;
	integer      draw;

	assign wb_dat_r = dat_q;
	assign wb_ack = ack_q;

	always @(posedge clk) begin
		wr_seen <= 1'b0;
		if (load)
			mem <= image;
		if (reset) begin
			ack_q <= 1'b0;
			busy <= 1'b0;
		end else if (ack_q) begin
			ack_q <= 1'b0;  // master drops cyc on this edge
			busy <= 1'b0;
		end else if (wb_cyc && wb_stb && !busy) begin
			draw = $random(seed);
			busy <= 1'b1;
			wait_left <= draw[1:0];
		end else if (busy && wait_left != 2'd0) begin
			wait_left <= wait_left - 2'd1;
		end else if (busy) begin
			ack_q <= 1'b1;
			if (wb_we) begin
				mem[wb_adr[11:2]] <= wb_dat_w;
				wr_seen <= 1'b1;
				wr_addr <= wb_adr;
				wr_data <= wb_dat_w;
			end else begin
				dat_q <= mem[wb_adr[11:2]];
			end
		end
	end

endmodule

//--- dv/tb_top.sv
`timescale 1ns/100ps
`include "mips_cfg.svh"

module tb_top;
	import mips_pkg::*;

	localparam int wait_limit = 5000;

	logic        clk;
	logic        reset;
	logic        restart = 1'b0;
	logic        load = 1'b0;
	logic [31:0] image [1024];  // program and data for the next run
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [31:0] wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic        wb_ack;
	logic        halted;
	logic        exception;
	logic        wr_seen;
	logic [31:0] wr_addr;
	logic [31:0] wr_data;

	logic [31:0] exp_addr [$];  // stores predicted by run_model
	logic [31:0] exp_data [$];
	int          put;
	int          wr_count;
	int          bus_starts;
	int          bus_acks;
	logic        cyc_q;
	logic        hold_valid;
	logic [31:0] hold_adr;
	logic [31:0] hold_dat;
	logic        hold_we;

	tb_clock u_clock (
		.restart(restart),
		.clk(clk),
		.reset(reset)
	);

	mips_core DUT (
		.clk(clk),
		.reset(reset),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.halted(halted),
		.exception(exception)
	);

	tb_mem u_mem (
		.clk(clk),
		.reset(reset),
		.load(load),
		.image(image),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.wr_seen(wr_seen),
		.wr_addr(wr_addr),
		.wr_data(wr_data)
	);

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want) begin
			$display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, want);
			$display("TB FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1, "run aborted");
	endtask

	function automatic logic [31:0] encode_r(funct_e fn, int rs, int rt, int rd);
		return {OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
	endfunction

	function automatic logic [31:0] encode_i(opcode_e op, int rs, int rt, int imm);
		return {op, 5'(rs), 5'(rt), 16'(imm)};
	endfunction

	function automatic logic [31:0] encode_j(int index);
		return {OP_J, 26'(index)};  // word index inside the region
	endfunction

	task automatic emit(input logic [31:0] word);
		image[put] = word;
		put++;
	endtask

	// ISA model returning 0 on BREAK, 1 on exception and 2 if it never ends
	function automatic int run_model();
		logic [31:0] m [1024];
		logic [31:0] r [32];
		logic [31:0] pc;
		logic [31:0] pc4;
		logic [31:0] ins;
		logic [31:0] simm;
		logic [31:0] zimm;
		logic [31:0] addr;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		m = image;
		for (int i = 0; i < 32; i++)
			r[i] = 32'd0;
		pc = `RESET_PC;
		exp_addr.delete();
		exp_data.delete();
		for (int step = 0; step < 2000; step++) begin
			ins = m[pc[11:2]];
			rs = ins[25:21];
			rt = ins[20:16];
			rd = ins[15:11];
			pc4 = pc + 32'd4;
			simm = {{16{ins[15]}}, ins[15:0]};
			zimm = {16'd0, ins[15:0]};
			addr = r[rs] + simm;
			pc = pc4;
			case (ins[31:26])
				OP_SPECIAL: begin
					case (ins[5:0])
						FN_ADDU: r[rd] = r[rs] + r[rt];
						FN_SUBU: r[rd] = r[rs] - r[rt];
						FN_AND:  r[rd] = r[rs] & r[rt];
						FN_OR:   r[rd] = r[rs] | r[rt];
						FN_SLT:  r[rd] = {31'd0, $signed(r[rs]) < $signed(r[rt])};
						FN_BREAK: return 0;
						default: return 1;
					endcase
				end
				OP_ADDIU: r[rt] = r[rs] + simm;
				OP_ORI:   r[rt] = r[rs] | zimm;
				OP_LUI:   r[rt] = {ins[15:0], 16'd0};
				OP_LW:    r[rt] = m[addr[11:2]];
				OP_SW: begin
					m[addr[11:2]] = r[rt];
					exp_addr.push_back(addr);
					exp_data.push_back(r[rt]);
				end
				OP_BEQ: if (r[rs] == r[rt]) pc = pc4 + {simm[29:0], 2'b00};
				OP_BNE: if (r[rs] != r[rt]) pc = pc4 + {simm[29:0], 2'b00};
				OP_J:   pc = {pc4[31:28], ins[25:0], 2'b00};
				default: return 1;
			endcase
			r[0] = 32'd0;  // hardwired zero
		end
		return 2;
	endfunction

	task automatic fill_image();
		for (int i = 0; i < 1024; i++)
			image[i] = {6'h3f, 16'd0, 10'(i)};  // illegal opcode tagged with its word index
		put = 0;
	endtask

	task automatic load_main_program();
		fill_image();
		image[10'h100] = 32'h1234_5678;  // load data at 0x400
		image[10'h101] = 32'h0000_0010;
		emit(encode_i(OP_LUI, 0, 1, 'h8000));
		emit(encode_i(OP_ORI, 1, 1, 'h0005));
		emit(encode_i(OP_ADDIU, 0, 2, -3));
		emit(encode_r(FN_ADDU, 1, 2, 3));
		emit(encode_r(FN_SUBU, 1, 2, 4));
		emit(encode_r(FN_AND, 1, 2, 5));
		emit(encode_r(FN_OR, 1, 2, 6));
		emit(encode_r(FN_SLT, 1, 2, 7));  // signed compare gives 1
		emit(encode_r(FN_SLT, 2, 1, 8));
		emit(encode_i(OP_ADDIU, 0, 10, 'h800));  // store base
		emit(encode_i(OP_SW, 10, 3, 0));
		emit(encode_i(OP_SW, 10, 4, 4));
		emit(encode_i(OP_SW, 10, 5, 8));
		emit(encode_i(OP_SW, 10, 6, 12));
		emit(encode_i(OP_SW, 10, 7, 16));
		emit(encode_i(OP_SW, 10, 8, 20));
		emit(encode_i(OP_SW, 10, 1, 24));
		emit(encode_i(OP_SW, 10, 2, 28));
		emit(encode_i(OP_ADDIU, 0, 11, 'h400));
		emit(encode_i(OP_LW, 11, 12, 0));
		emit(encode_i(OP_LW, 11, 0, 4));  // r0 must stay zero
		emit(encode_i(OP_LW, 11, 13, 4));
		emit(encode_r(FN_ADDU, 12, 13, 14));
		emit(encode_i(OP_SW, 10, 14, 32));
		emit(encode_i(OP_SW, 10, 0, 36));
		emit(encode_i(OP_BEQ, 12, 12, 1));  // taken
		emit(encode_i(OP_SW, 10, 12, 40));
		emit(encode_i(OP_BNE, 12, 12, 1));  // not taken
		emit(encode_i(OP_SW, 10, 13, 44));
		emit(encode_i(OP_BNE, 12, 13, 2));  // taken and skips two
		emit(encode_i(OP_SW, 10, 12, 48));
		emit(encode_i(OP_SW, 10, 12, 52));
		emit(encode_i(OP_BEQ, 12, 13, 1));  // not taken
		emit(encode_j(37));
		emit(encode_i(OP_SW, 10, 14, 64));  // word 34 is reached last
		emit(encode_r(FN_BREAK, 0, 0, 0));
		emit(encode_i(OP_SW, 10, 12, 56));
		emit(encode_i(OP_SW, 10, 3, 60));  // word 37
		emit(encode_j(34));
	endtask

	task automatic load_fault_program();
		fill_image();
		emit(encode_i(OP_ADDIU, 0, 1, 'h55));
		emit(encode_i(OP_ADDIU, 0, 10, 'h800));
		emit(encode_i(OP_SW, 10, 1, 0));
		emit(encode_i(OP_BNE, 1, 0, 1));
		emit(encode_i(OP_SW, 10, 1, 4));
		emit(encode_i(OP_SW, 10, 1, 8));
		emit(32'hfc00_0000);  // undefined opcode
		emit(encode_i(OP_SW, 10, 1, 12));
		emit(encode_r(FN_BREAK, 0, 0, 0));
	endtask

	task automatic wait_reset_done();
		int n;
		n = 0;
		while (reset && n < wait_limit) begin
			@(posedge clk);
			n++;
		end
		if (reset)
			abort_run("timeout waiting for reset to be released");
	endtask

	task automatic wait_halted();
		int n;
		n = 0;
		while (!halted && n < wait_limit) begin
			@(posedge clk);
			n++;
		end
		if (!halted)
			abort_run("timeout waiting for the core to halt");
	endtask

	task automatic run_program(input string label, input int want_end);
		int model_end;
		model_end = run_model();
		if (model_end != want_end)
			abort_run({label, ": reference model did not end as intended"});
		@(posedge clk);
		restart <= 1'b1;
		load <= 1'b1;
		@(posedge clk);
		restart <= 1'b0;
		load <= 1'b0;
		@(posedge clk);
		wait_reset_done();
		wait_halted();
		check_value("exception", 32'(exception), 32'(want_end));
		repeat (50) begin
			@(posedge clk);
			check_value("wb_cyc", 32'(wb_cyc), 32'd0);  // no bus cycle once halted
			check_value("halted", 32'(halted), 32'd1);
			check_value("exception", 32'(exception), 32'(want_end));
		end
		check_value("store count", 32'(wr_count), 32'(exp_addr.size()));
		check_value("ack count", 32'(bus_acks), 32'(bus_starts));
	endtask

	// compare every logged write with the model's list
	always @(posedge clk) begin
		if (reset) begin
			wr_count <= 0;
		end else if (wr_seen) begin
			if (wr_count >= exp_addr.size()) begin
				abort_run("store seen beyond the end of the model's store list");
			end else begin
				check_value("wb_adr", wr_addr, exp_addr[wr_count]);
				check_value("wb_dat_w", wr_data, exp_data[wr_count]);
				wr_count <= wr_count + 1;
			end
		end
	end

	// bus protocol monitor
	always @(posedge clk) begin
		if (reset) begin
			hold_valid <= 1'b0;
			cyc_q <= 1'b0;
			bus_starts <= 0;
			bus_acks <= 0;
		end else begin
			check_value("wb_stb", 32'(wb_stb), 32'(wb_cyc));  // stb follows cyc in a classic cycle
			if (hold_valid) begin
				check_value("wb_adr", wb_adr, hold_adr);
				check_value("wb_we", 32'(wb_we), 32'(hold_we));
				check_value("wb_dat_w", wb_dat_w, hold_dat);
			end
			if (wb_ack && !wb_cyc)
				abort_run("ack raised outside a bus cycle");
			if (wb_cyc && !cyc_q)
				bus_starts <= bus_starts + 1;
			if (wb_cyc && wb_ack)
				bus_acks <= bus_acks + 1;
			cyc_q <= wb_cyc;
			hold_valid <= wb_cyc && !wb_ack;  // still waiting on the slave
			hold_adr <= wb_adr;
			hold_we <= wb_we;
			hold_dat <= wb_dat_w;
		end
	end

	initial begin
		load_main_program();
		run_program("main program", 0);
		load_fault_program();
		run_program("fault program", 1);
		$display("TB PASSED");
		$finish;
	end

endmodule

//--- list.f
+incdir+src
src/mips_pkg.sv
src/alu.sv
src/pc_unit.sv
src/regfile.sv
src/wb_master.sv
src/controller.sv
src/mips_core.sv
dv/tb_clock.sv
dv/tb_mem.sv
dv/tb_top.sv

//--- run.sh
#!/bin/sh
# build with Verilator and run; the exit status is the test result
cd "$(dirname "$0")" &&
verilator --binary -j 0 --timescale 1ns/100ps --top-module tb_top -f list.f -o tb_sim &&
./obj_dir/tb_sim || exit 1

//--- src/alu.sv
`timescale 1ns/100ps

module alu (
	input  logic [31:0]       a,
	input  logic [31:0]       b,
	input  mips_pkg::alu_op_e op,
	output logic [31:0]       result,
	output logic              zero  // result is all zero
);
	import mips_pkg::*;

	always_comb begin
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_SLT: result = {31'd0, $signed(a) < $signed(b)};  // signed compare
			ALU_LUI: result = {b[15:0], 16'd0};
			default: result = 32'd0;
		endcase
	end

	// BEQ/BNE look at this after a SUB
	assign zero = (result == 32'd0);

endmodule

//--- src/controller.sv
`timescale 1ns/100ps
`include "mips_cfg.svh"

module controller (
	input  logic                clk,
	input  logic                reset,
	input  logic                bus_done,      // transfer finished and rdata valid
	input  logic [31:0]         bus_rdata,
	input  logic                alu_zero,
	output logic                bus_req,       // one cycle start pulse
	output logic                bus_we,
	output logic                data_access,   // data address instead of pc
	output logic [31:0]         instr,
	output logic                pc_write,
	output mips_pkg::pc_src_e   pc_src,
	output logic [`REG_AW-1:0]  rs_addr,
	output logic [`REG_AW-1:0]  rt_addr,
	output logic [`REG_AW-1:0]  rd_addr,       // write destination
	output logic                reg_write,
	output mips_pkg::alu_op_e   alu_op,
	output logic                alu_b_imm,
	output logic                imm_zero_ext,
	output logic                wb_sel_load,
	output logic                halted,
	output logic                exception
);
	import mips_pkg::*;

	ctrl_state_e state;
	logic        req_sent;  // request of this state already issued
	opcode_e     opcode;
	funct_e      funct;
	logic        dest_rd;
	logic        writes_reg;
	logic        is_load;
	logic        is_store;
	logic        is_beq;
	logic        is_bne;
	logic        is_jump;
	logic        is_break;
	logic        illegal;

	assign opcode = opcode_e'(instr[31:26]);
	assign funct = funct_e'(instr[5:0]);

	// field decode
	always_comb begin
		alu_op = ALU_ADD;
		alu_b_imm = 1'b1;
		imm_zero_ext = 1'b0;
		dest_rd = 1'b0;
		writes_reg = 1'b0;
		is_load = 1'b0;
		is_store = 1'b0;
		is_beq = 1'b0;
		is_bne = 1'b0;
		is_jump = 1'b0;
		is_break = 1'b0;
		illegal = 1'b0;
		case (opcode)
			OP_SPECIAL: begin
				alu_b_imm = 1'b0;
				dest_rd = 1'b1;
				writes_reg = 1'b1;
				case (funct)
					FN_ADDU: alu_op = ALU_ADD;
					FN_SUBU: alu_op = ALU_SUB;
					FN_AND:  alu_op = ALU_AND;
					FN_OR:   alu_op = ALU_OR;
					FN_SLT:  alu_op = ALU_SLT;
					FN_BREAK: begin
						writes_reg = 1'b0;
						is_break = 1'b1;
					end
					default: begin
						writes_reg = 1'b0;
						illegal = 1'b1;
					end
				endcase
			end
			OP_ADDIU: writes_reg = 1'b1;
			OP_ORI: begin
				alu_op = ALU_OR;
				imm_zero_ext = 1'b1;
				writes_reg = 1'b1;
			end
			OP_LUI: begin
				alu_op = ALU_LUI;
				writes_reg = 1'b1;
			end
			OP_LW: begin
				writes_reg = 1'b1;
				is_load = 1'b1;
			end
			OP_SW: is_store = 1'b1;
			OP_BEQ: begin
				alu_op = ALU_SUB;  // zero flag means equal
				alu_b_imm = 1'b0;
				is_beq = 1'b1;
			end
			OP_BNE: begin
				alu_op = ALU_SUB;
				alu_b_imm = 1'b0;
				is_bne = 1'b1;
			end
			OP_J: is_jump = 1'b1;
			default: illegal = 1'b1;
		endcase
	end

	assign rs_addr = instr[25:21];
	assign rt_addr = instr[20:16];
	assign rd_addr = dest_rd ? instr[15:11] : instr[20:16];

	// next pc used only when pc_write is high
	always_comb begin
		if (is_jump)
			pc_src = PC_JUMP;
		else if ((is_beq && alu_zero) || (is_bne && !alu_zero))
			pc_src = PC_BRANCH;
		else
			pc_src = PC_SEQ;
	end

	assign bus_req = (state == ST_FETCH || state == ST_MEMORY) && !req_sent;
	assign bus_we = is_store && (state == ST_MEMORY);  // fetches always read
	assign data_access = (state == ST_MEMORY);
	assign pc_write = (state == ST_WRITEBACK);
	assign reg_write = (state == ST_WRITEBACK) && writes_reg;
	assign wb_sel_load = is_load;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_FETCH;
			req_sent <= 1'b0;
			halted <= 1'b0;
			exception <= 1'b0;
		end else begin
			req_sent <= bus_req || (req_sent && !bus_done);
			case (state)
				ST_FETCH: if (bus_done) state <= ST_DECODE;
				ST_DECODE: begin
					if (illegal) begin
						exception <= 1'b1;
						halted <= 1'b1;
						state <= ST_HALT;
					end else if (is_break) begin
						halted <= 1'b1;
						state <= ST_HALT;
					end else begin
						state <= ST_EXECUTE;
					end
				end
				ST_EXECUTE: state <= (is_load || is_store) ? ST_MEMORY : ST_WRITEBACK;
				ST_MEMORY: if (bus_done) state <= ST_WRITEBACK;
				ST_WRITEBACK: state <= ST_FETCH;
				default: state <= ST_HALT;  // stays until reset
			endcase
		end
	end

	// instruction register
	always_ff @(posedge clk) begin
		if (state == ST_FETCH && bus_done)
			instr <= bus_rdata;
	end

endmodule

//--- src/mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// address of the first instruction fetched after reset
`define RESET_PC 32'h0000_0000

// general purpose register file
`define REG_COUNT 32
`define REG_AW 5

`endif

//--- src/mips_core.sv
`timescale 1ns/100ps
`include "mips_cfg.svh"

module mips_core (
	input  logic        clk,        // main clock
	input  logic        reset,      // synchronous, active high
	output logic        wb_cyc,
	output logic        wb_stb,
	output logic        wb_we,
	output logic [31:0] wb_adr,
	output logic [31:0] wb_dat_w,
	input  logic [31:0] wb_dat_r,
	input  logic        wb_ack,
	output logic        halted,     // BREAK or bad encoding seen
	output logic        exception   // bad encoding seen
);
	import mips_pkg::*;

	// controller outputs
	logic                bus_req;
	logic                bus_we;
	logic                data_access;
	logic [31:0]         instr;
	logic                pc_write;
	pc_src_e             pc_src;
	logic [`REG_AW-1:0]  rs_addr;
	logic [`REG_AW-1:0]  rt_addr;
	logic [`REG_AW-1:0]  rd_addr;
	logic                reg_write;
	alu_op_e             alu_op;
	logic                alu_b_imm;
	logic                imm_zero_ext;
	logic                wb_sel_load;

	// datapath results
	logic                bus_done;
	logic [31:0]         bus_rdata;
	logic [31:0]         pc;
	logic [31:0]         rd_a;
	logic [31:0]         rd_b;
	logic [31:0]         imm_ext;
	logic [31:0]         alu_b;
	logic [31:0]         alu_result;
	logic                alu_zero;
	logic [31:0]         reg_wd;

	assign imm_ext = imm_zero_ext ? {16'b0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
	assign alu_b = alu_b_imm ? imm_ext : rd_b;
	assign reg_wd = wb_sel_load ? bus_rdata : alu_result;  // load data or alu result

	controller u_controller (
		.clk(clk),
		.reset(reset),
		.bus_done(bus_done),
		.bus_rdata(bus_rdata),
		.alu_zero(alu_zero),
		.bus_req(bus_req),
		.bus_we(bus_we),
		.data_access(data_access),
		.instr(instr),
		.pc_write(pc_write),
		.pc_src(pc_src),
		.rs_addr(rs_addr),
		.rt_addr(rt_addr),
		.rd_addr(rd_addr),
		.reg_write(reg_write),
		.alu_op(alu_op),
		.alu_b_imm(alu_b_imm),
		.imm_zero_ext(imm_zero_ext),
		.wb_sel_load(wb_sel_load),
		.halted(halted),
		.exception(exception)
	);

	pc_unit u_pc_unit (
		.clk(clk),
		.reset(reset),
		.pc_write(pc_write),
		.pc_src(pc_src),
		.instr(instr),
		.pc(pc)
	);

	regfile u_regfile (
		.clk(clk),
		.reset(reset),
		.ra(rs_addr),
		.rb(rt_addr),
		.wa(rd_addr),
		.wd(reg_wd),
		.we(reg_write),
		.rd_a(rd_a),
		.rd_b(rd_b)
	);

	alu u_alu (
		.a(rd_a),
		.b(alu_b),
		.op(alu_op),
		.result(alu_result),
		.zero(alu_zero)
	);

	wb_master u_wb_master (
		.clk(clk),
		.reset(reset),
		.bus_req(bus_req),
		.bus_we(bus_we),
		.data_access(data_access),
		.fetch_addr(pc),
		.data_addr(alu_result),  // rs + offset for LW/SW
		.wdata(rd_b),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.bus_done(bus_done),
		.bus_rdata(bus_rdata),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w)
	);

endmodule

//--- src/mips_pkg.sv
package mips_pkg;

	// primary opcode field, instr[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,  // register ops, see funct
		OP_J       = 6'h02,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05,
		OP_ADDIU   = 6'h09,
		OP_ORI     = 6'h0d,
		OP_LUI     = 6'h0f,
		OP_LW      = 6'h23,
		OP_SW      = 6'h2b
	} opcode_e;

	// function field of SPECIAL, instr[5:0]
	typedef enum logic [5:0] {
		FN_BREAK = 6'h0d,
		FN_ADDU  = 6'h21,
		FN_SUBU  = 6'h23,
		FN_AND   = 6'h24,
		FN_OR    = 6'h25,
		FN_SLT   = 6'h2a
	} funct_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT,
		ALU_LUI
	} alu_op_e;

	typedef enum logic [1:0] {
		PC_SEQ,     // pc + 4
		PC_BRANCH,  // pc + 4 + offset
		PC_JUMP     // region of pc + 4 with index
	} pc_src_e;

	typedef enum logic [2:0] {
		ST_FETCH,
		ST_DECODE,
		ST_EXECUTE,
		ST_MEMORY,
		ST_WRITEBACK,
		ST_HALT
	} ctrl_state_e;

endpackage

//--- src/pc_unit.sv
`timescale 1ns/100ps
`include "mips_cfg.svh"

module pc_unit (
	input  logic              clk,
	input  logic              reset,
	input  logic              pc_write,  // update on writeback
	input  mips_pkg::pc_src_e pc_src,
	input  logic [31:0]       instr,
	output logic [31:0]       pc
);
	import mips_pkg::*;

	logic [31:0] pc_plus4;
	logic [31:0] branch_target;
	logic [31:0] jump_target;

	assign pc_plus4 = pc + 32'd4;
	assign branch_target = pc_plus4 + {{14{instr[15]}}, instr[15:0], 2'b00};
	assign jump_target = {pc_plus4[31:28], instr[25:0], 2'b00};  // same 256 MB region

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= `RESET_PC;
		end else if (pc_write) begin
			case (pc_src)
				PC_BRANCH: pc <= branch_target;
				PC_JUMP:   pc <= jump_target;
				default:   pc <= pc_plus4;
			endcase
		end
	end

endmodule

//--- src/regfile.sv
`timescale 1ns/100ps
`include "mips_cfg.svh"

module regfile (
	input  logic [`REG_AW-1:0] ra,
	input  logic [`REG_AW-1:0] rb,
	input  logic [`REG_AW-1:0] wa,
	input  logic [31:0]        wd,
	input  logic               we,
	input  logic               clk,
	input  logic               reset,
	output logic [31:0]        rd_a,
	output logic [31:0]        rd_b
);

	logic [31:0] regs [`REG_COUNT];

	// async read, r0 hardwired
	assign rd_a = (ra == '0) ? 32'd0 : regs[ra];
	assign rd_b = (rb == '0) ? 32'd0 : regs[rb];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= 32'd0;
		end else if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

endmodule

//--- src/wb_master.sv
`timescale 1ns/100ps

module wb_master (
	input  logic        clk,
	input  logic        reset,
	input  logic        bus_req,      // start pulse from controller
	input  logic        bus_we,
	input  logic        data_access,  // pick data_addr over fetch_addr
	input  logic [31:0] fetch_addr,
	input  logic [31:0] data_addr,
	input  logic [31:0] wdata,
	input  logic [31:0] wb_dat_r,
	input  logic        wb_ack,
	output logic        bus_done,
	output logic [31:0] bus_rdata,    // held until next request
	output logic        wb_cyc,
	output logic        wb_stb,
	output logic        wb_we,
	output logic [31:0] wb_adr,
	output logic [31:0] wb_dat_w
);

	logic ack_seen;

	assign ack_seen = wb_cyc && wb_ack;

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_cyc <= 1'b0;
			wb_stb <= 1'b0;
			wb_we <= 1'b0;
			bus_done <= 1'b0;
		end else begin
			bus_done <= ack_seen;
			if (bus_req) begin
				wb_cyc <= 1'b1;
				wb_stb <= 1'b1;
				wb_we <= bus_we;
			end else if (ack_seen) begin
				wb_cyc <= 1'b0;  // end of classic cycle
				wb_stb <= 1'b0;
				wb_we <= 1'b0;
			end
		end
	end

	// address and data stay put while waiting for ack
	always_ff @(posedge clk) begin
		if (bus_req) begin
			wb_adr <= data_access ? data_addr : fetch_addr;
			wb_dat_w <= wdata;
		end
		if (ack_seen && !wb_we)
			bus_rdata <= wb_dat_r;
	end

endmodule
